// File: include/mm_cfg.svh
// Sizes for the 2x2 block matrix engine
// Operand RAMs hold I and W as 2x2 blocks of Q8.8 elements, one block per word
// Both matrices must have the same number of block rows (one MM_WORDS for both RAMs)
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

`define MM_WIDTH    16  // Element width in bits
`define MM_FRAC     8   // Fraction bits of Q8.8
`define MM_BLOCK    2   // Block edge
`define MM_INNER    4   // Shared inner dimension
`define MM_I_OUTER  6   // Rows of I
`define MM_W_OUTER  6   // Rows of W

// Block counts
`define MM_KBLK     (`MM_INNER / `MM_BLOCK)
`define MM_IBLK     (`MM_I_OUTER / `MM_BLOCK)
`define MM_WBLK     (`MM_W_OUTER / `MM_BLOCK)

// RAM geometry
`define MM_WORDS    (`MM_IBLK * `MM_KBLK)
`define MM_AW       3
`define MM_WORD_W   (`MM_WIDTH * `MM_BLOCK * `MM_BLOCK)
`define MM_BE_W     (`MM_WORD_W / 8)

`endif

// File: source/mm_pkg.sv
// Shared types of the block engine
// acc_t is 32 bits, so a sum that holds -32768 * -32768 more than once wraps
`include "mm_cfg.svh"

package mm_pkg;

    typedef logic signed [`MM_WIDTH-1:0] elem_t;       // Q8.8
    typedef logic signed [2*`MM_WIDTH-1:0] acc_t;      // Q16.16 sums

    // One RAM word, seen as elements or as write lanes
    typedef union packed {
        elem_t [`MM_BLOCK*`MM_BLOCK-1:0] elem;         // elem[0] is r0c0, row-major
        logic [`MM_BE_W-1:0][7:0] bytes;
    } block_word_t;

    localparam acc_t SAT_MAX = (acc_t'(1) <<< (`MM_WIDTH - 1)) - acc_t'(1);
    localparam acc_t SAT_MIN = -(acc_t'(1) <<< (`MM_WIDTH - 1));

    // Q16.16 back to Q8.8 with clamp
    function automatic elem_t scale_sat(acc_t acc);
        acc_t shifted;
        shifted = acc >>> `MM_FRAC;                     // Arithmetic, rounds toward -inf
        if (shifted > SAT_MAX) return elem_t'(SAT_MAX);
        if (shifted < SAT_MIN) return elem_t'(SAT_MIN);
        return elem_t'(shifted);
    endfunction

endpackage

// File: source/tile_if.sv
// One operand block pair per cycle from the sequencer to the MAC
// Flags are driven by the controller, block words come straight from the RAMs
interface tile_if;
    import mm_pkg::*;

    logic        valid;     // Pair present this cycle
    logic        first;     // k == 0, accumulator loads
    logic        last;      // Final k of the output block
    logic        job_end;   // Final pair of the whole job
    block_word_t a_blk;     // Block of I
    block_word_t w_blk;     // Block of W

    // Sequencer side
    modport ctrl (
        output valid, first, last, job_end
    );

    // MAC side
    modport mac (
        input valid, first, last, job_end, a_blk, w_blk
    );

endinterface

// File: source/block_ram.sv
// Behavioral simple dual port RAM, one block word per address
// Byte lane write enables, 1 cycle registered read
// Addresses at or above MM_WORDS are ignored on write and read back as don't care
`include "mm_cfg.svh"

module block_ram (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_en,
    input  logic [`MM_BE_W-1:0]       wr_be,
    input  logic [`MM_AW-1:0]         wr_addr,
    input  mm_pkg::block_word_t       wr_data,
    input  logic                      rd_en,
    input  logic [`MM_AW-1:0]         rd_addr,
    output mm_pkg::block_word_t       rd_data
);
    import mm_pkg::*;

    localparam int WORDS = `MM_WORDS;
    localparam int LANES = `MM_BE_W;

    block_word_t mem [WORDS];   // No reset, contents come from the host

    // Lane merge through the byte view
    always_ff @(posedge clk) begin
        if (wr_en && (int'(wr_addr) < WORDS)) begin
            for (int b = 0; b < LANES; b++) begin
                if (wr_be[b]) mem[wr_addr].bytes[b] <= wr_data.bytes[b];
            end
        end
    end

    // Read port, holds last word while idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: source/block_mac.sv
// Two stage 2x2 block multiply accumulate, computes A times transpose of W
// Accepts one tile per cycle with no stall, result appears 3 edges after the last tile
// Accumulator has no reset, the first tile of each block reloads it
`include "mm_cfg.svh"

module block_mac (
    input  logic                clk,
    input  logic                rst_n,
    tile_if.mac                 tile,
    output mm_pkg::block_word_t result,
    output logic                out_valid,
    output logic                done
);
    import mm_pkg::*;

    localparam int B = `MM_BLOCK;
    localparam int N = B * B;   // Elements per block

    // Stage 1 products, [output elem][inner index]
    acc_t prod [N][B];
    logic s1_valid;
    logic s1_first;
    logic s1_last;
    logic s1_end;

    // Stage 2 accumulators
    acc_t pair_sum [N];
    acc_t acc [N];
    logic s2_valid;
    logic s2_last;
    logic s2_end;

    // C[r][c] pulls row r of A against row c of W
    always_ff @(posedge clk) begin
        if (tile.valid) begin
            for (int r = 0; r < B; r++) begin
                for (int c = 0; c < B; c++) begin
                    for (int m = 0; m < B; m++) begin
                        prod[r*B+c][m] <= acc_t'(tile.a_blk.elem[r*B+m])
                                        * acc_t'(tile.w_blk.elem[c*B+m]);  // Exact Q16.16
                    end
                end
            end
        end
        s1_first <= tile.first;     // Flags ride with the products
        s1_last  <= tile.last;
        s1_end   <= tile.job_end;
    end

    // Sum over the inner index of one tile
    always_comb begin
        for (int e = 0; e < N; e++) begin
            pair_sum[e] = '0;
            for (int m = 0; m < B; m++) begin
                pair_sum[e] = pair_sum[e] + prod[e][m];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int e = 0; e < N; e++) begin
                acc[e] <= s1_first ? pair_sum[e] : acc[e] + pair_sum[e];  // Load or add
            end
        end
        s2_last <= s1_last;
        s2_end  <= s1_end;
    end

    // Scaled and clamped block, held until the next one
    always_ff @(posedge clk) begin
        if (s2_valid && s2_last) begin
            for (int e = 0; e < N; e++) begin
                result.elem[e] <= scale_sat(acc[e]);
            end
        end
    end

    // Valid chain, cleared on reset so a stale tile never surfaces
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            s1_valid  <= tile.valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid && s2_last;
            done      <= s2_valid && s2_last && s2_end;   // With the final block
        end
    end

endmodule

// File: source/mm_controller.sv
// Job sequencer, walks output blocks (i,j) row-major and k inside each
// Issues one read pair per cycle after start, 18 pairs back to back
// start is dropped while busy, busy drops on the edge that sees done
`include "mm_cfg.svh"

module mm_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                done,
    output logic                rd_en,
    output logic [`MM_AW-1:0]   in_rd_addr,
    output logic [`MM_AW-1:0]   wb_rd_addr,
    tile_if.ctrl                tile,
    output logic                busy
);
    localparam int AW = `MM_AW;
    localparam logic [AW-1:0] KBLK = AW'(`MM_KBLK);
    localparam logic [AW-1:0] IBLK = AW'(`MM_IBLK);
    localparam logic [AW-1:0] WBLK = AW'(`MM_WBLK);

    logic          active;      // Issue phase
    logic [AW-1:0] k_cnt;       // Inner block
    logic [AW-1:0] col_cnt;     // Output block column, W block row
    logic [AW-1:0] row_cnt;     // Output block row, I block row
    logic          k_wrap;
    logic          col_wrap;
    logic          job_last;

    // Flags of the pair issued last edge
    logic iss_first;
    logic iss_last;
    logic iss_end;

    assign k_wrap   = (k_cnt == KBLK - 1'b1);
    assign col_wrap = (col_cnt == WBLK - 1'b1);
    assign job_last = k_wrap && col_wrap && (row_cnt == IBLK - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            active     <= 1'b0;
            rd_en      <= 1'b0;
            tile.valid <= 1'b0;
            k_cnt      <= '0;
            col_cnt    <= '0;
            row_cnt    <= '0;
        end else begin
            if (start && !busy) begin
                busy   <= 1'b1;
                active <= 1'b1;     // First issue on the next edge
            end else if (done && !active) begin
                busy   <= 1'b0;
            end
            rd_en      <= active;
            tile.valid <= rd_en;    // Lines up with RAM data
            if (active) begin
                if (k_wrap) begin
                    k_cnt <= '0;
                    if (col_wrap) begin
                        col_cnt <= '0;
                        row_cnt <= job_last ? '0 : row_cnt + 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end else begin
                    k_cnt <= k_cnt + 1'b1;
                end
                if (job_last) active <= 1'b0;  // Counters back at zero for the next job
            end
        end
    end

    // Addresses and tags, qualified by rd_en and valid
    always_ff @(posedge clk) begin
        if (active) begin
            in_rd_addr <= k_cnt + row_cnt * KBLK;
            wb_rd_addr <= k_cnt + col_cnt * KBLK;
            iss_first  <= (k_cnt == '0);
            iss_last   <= k_wrap;
            iss_end    <= job_last;
        end
        tile.first   <= iss_first;
        tile.last    <= iss_last;
        tile.job_end <= iss_end;
    end

endmodule

// File: source/mm_top.sv
// Block matrix engine, C = I times transpose of W in 2x2 Q8.8 blocks
// Load both RAMs while idle, then pulse start
// out_block is valid only with out_valid and is not held for the host
`include "mm_cfg.svh"

module mm_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    in_en,
    input  logic [`MM_BE_W-1:0]     in_we,
    input  logic [`MM_AW-1:0]       in_addr,
    input  logic [`MM_WORD_W-1:0]   in_din,
    input  logic                    wb_en,
    input  logic [`MM_BE_W-1:0]     wb_we,
    input  logic [`MM_AW-1:0]       wb_addr,
    input  logic [`MM_WORD_W-1:0]   wb_din,
    output logic [`MM_WORD_W-1:0]   out_block,
    output logic                    out_valid,
    output logic                    done,
    output logic                    busy
);
    import mm_pkg::*;

    logic              rd_en;       // Shared by both RAMs
    logic [`MM_AW-1:0] in_rd_addr;
    logic [`MM_AW-1:0] wb_rd_addr;
    block_word_t       in_rd_data;
    block_word_t       wb_rd_data;
    block_word_t       result;

    tile_if tile_bus ();

    // RAM data goes straight onto the tile bus
    assign tile_bus.a_blk = in_rd_data;
    assign tile_bus.w_blk = wb_rd_data;
    assign out_block      = result;

    block_ram u_in_ram (
        .clk(clk), .rst_n(rst_n),
        .wr_en(in_en), .wr_be(in_we), .wr_addr(in_addr), .wr_data(in_din),
        .rd_en(rd_en), .rd_addr(in_rd_addr), .rd_data(in_rd_data)
    );

    block_ram u_wb_ram (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wb_en), .wr_be(wb_we), .wr_addr(wb_addr), .wr_data(wb_din),
        .rd_en(rd_en), .rd_addr(wb_rd_addr), .rd_data(wb_rd_data)
    );

    mm_controller u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .done(done),
        .rd_en(rd_en), .in_rd_addr(in_rd_addr), .wb_rd_addr(wb_rd_addr),
        .tile(tile_bus.ctrl), .busy(busy)
    );

    block_mac u_mac (
        .clk(clk), .rst_n(rst_n), .tile(tile_bus.mac),
        .result(result), .out_valid(out_valid), .done(done)
    );

endmodule

// File: tests/mm_assert.sv
// Protocol checks on the top level strobes, bound into mm_top
// Sampled on the rising clock edge, reset check is the only one active during reset
module mm_assert (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic out_valid,
    input logic done,
    input logic busy
);

    // Result strobe only inside a job
    valid_in_job: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> busy)
        else $error("out_valid seen while the engine is not busy");

    // done rides on the ninth result
    done_with_block: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> out_valid)
        else $error("done pulsed without a result block");

    // Synchronous reset clears the strobes on the next edge
    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> (!out_valid && !done && !busy))
        else $error("outputs still active in the cycle after reset");

    // A job is only entered through start
    busy_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(start))
        else $error("busy rose without a start pulse");

endmodule

bind mm_top mm_assert u_assert (
    .clk(clk), .rst_n(rst_n), .start(start),
    .out_valid(out_valid), .done(done), .busy(busy)
);

// File: tests/mm_tb.sv
// Random matrices from a 16 bit Galois LFSR with seed 12 are checked against a shadow model
// Model keeps the accumulator at 32 bits like acc_t so huge sums wrap the same way
// Inputs change and outputs are read on the falling edge
`include "mm_cfg.svh"

module mm_tb;

    localparam int B         = `MM_BLOCK;
    localparam int WORDS     = `MM_WORDS;
    localparam int BLOCKS    = `MM_IBLK * `MM_WBLK;        // Output blocks per job
    localparam int PAIRS     = BLOCKS * `MM_KBLK;          // Tile pairs per job
    localparam int SAT_HI    = (1 << (`MM_WIDTH - 1)) - 1;
    localparam int SAT_LO    = -(1 << (`MM_WIDTH - 1));
    localparam int JOBS      = 8;
    localparam int WRITE_CYC = 2 * WORDS;                  // Full reload of both RAMs
    localparam int CYCLE_LIMIT = JOBS * (WRITE_CYC + PAIRS + 10) + 100;
    localparam int DONE_WAIT = PAIRS + 20;
    localparam logic [15:0] SEED = 16'd12;
    localparam logic [15:0] TAPS = 16'hB400;               // x^16 + x^14 + x^13 + x^11 + 1

    logic clk;
    logic rst_n;
    logic start;
    logic in_en;
    logic [`MM_BE_W-1:0] in_we;
    logic [`MM_AW-1:0] in_addr;
    logic [`MM_WORD_W-1:0] in_din;
    logic wb_en;
    logic [`MM_BE_W-1:0] wb_we;
    logic [`MM_AW-1:0] wb_addr;
    logic [`MM_WORD_W-1:0] wb_din;
    logic [`MM_WORD_W-1:0] out_block;
    logic out_valid;
    logic done;
    logic busy;

    logic [15:0] lfsr;
    logic [`MM_WORD_W-1:0] in_mem [WORDS];     // Shadow of the input RAM
    logic [`MM_WORD_W-1:0] wb_mem [WORDS];     // Shadow of the weight RAM
    logic [`MM_WORD_W-1:0] exp_q [$];          // Expected blocks, row-major
    int cycle_cnt = 0;
    int blk_idx = 0;
    int job_valid = 0;
    int job_done = 0;
    int done_total = 0;
    int jobs_run = 0;
    int sat_hits = 0;

    mm_top uut (
        .clk(clk), .rst_n(rst_n), .start(start),
        .in_en(in_en), .in_we(in_we), .in_addr(in_addr), .in_din(in_din),
        .wb_en(wb_en), .wb_we(wb_we), .wb_addr(wb_addr), .wb_din(wb_din),
        .out_block(out_block), .out_valid(out_valid), .done(done), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped at time %0t", $time);
    endtask

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Magnitude 48.0 to 64.0 with random sign
    function automatic logic [15:0] big_elem();
        logic [15:0] mag;
        mag = 16'h3000 | 16'(rand_bits(12));
        if (rand_bits(1) != 0) return -mag;
        return mag;
    endfunction

    // Matrix element from block-row-major storage
    function automatic int elem_at(input bit from_wb, input int row, input int col);
        logic [15:0] v;
        int word;
        int e;
        word = (row / B) * `MM_KBLK + col / B;
        e = (row % B) * B + col % B;
        v = from_wb ? wb_mem[word][16*e +: 16] : in_mem[word][16*e +: 16];
        return int'($signed(v));
    endfunction

    function automatic logic [15:0] clamp_q88(input int v);
        if (v > SAT_HI) return 16'h7FFF;
        if (v < SAT_LO) return 16'h8000;
        return v[15:0];
    endfunction

    // Byte merge into the shadow plus one write cycle on the DUT
    task automatic write_word(input bit to_wb, input int addr, input logic [7:0] be,
                              input logic [63:0] data);
        for (int b = 0; b < `MM_BE_W; b++) begin
            if (be[b] && to_wb) wb_mem[addr][8*b +: 8] = data[8*b +: 8];
            if (be[b] && !to_wb) in_mem[addr][8*b +: 8] = data[8*b +: 8];
        end
        if (to_wb) begin
            wb_en = 1'b1;
            wb_we = be;
            wb_addr = `MM_AW'(addr);
            wb_din = data;
        end else begin
            in_en = 1'b1;
            in_we = be;
            in_addr = `MM_AW'(addr);
            in_din = data;
        end
        @(negedge clk);
        in_en = 1'b0;
        wb_en = 1'b0;
    endtask

    task automatic load_random(input bit to_wb);
        for (int a = 0; a < WORDS; a++) write_word(to_wb, a, 8'hFF, rand_bits(64));
    endtask

    task automatic load_large(input bit to_wb);
        logic [63:0] word;
        for (int a = 0; a < WORDS; a++) begin
            for (int e = 0; e < B * B; e++) word[16*e +: 16] = big_elem();
            write_word(to_wb, a, 8'hFF, word);
        end
    endtask

    // C = I * W^T with 32 bit accumulate, shift by 8 and clamp
    task automatic queue_job();
        logic [`MM_WORD_W-1:0] blk;
        int acc;
        int scaled;
        sat_hits = 0;
        for (int bi = 0; bi < `MM_IBLK; bi++) begin
            for (int bj = 0; bj < `MM_WBLK; bj++) begin
                blk = '0;
                for (int r = 0; r < B; r++) begin
                    for (int c = 0; c < B; c++) begin
                        acc = 0;
                        for (int k = 0; k < `MM_INNER; k++) begin
                            acc += elem_at(1'b0, bi*B + r, k) * elem_at(1'b1, bj*B + c, k);
                        end
                        scaled = acc >>> `MM_FRAC;      // Toward -inf
                        if (scaled > SAT_HI || scaled < SAT_LO) sat_hits++;
                        blk[16*(r*B + c) +: 16] = clamp_q88(scaled);
                    end
                end
                exp_q.push_back(blk);
            end
        end
    endtask

    // extra_starts pulses land while busy and must be ignored
    task automatic run_job(input int extra_starts);
        int n;
        queue_job();
        job_valid = 0;
        job_done = 0;
        blk_idx = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (busy) else abort_run("busy did not rise after start");
        n = 0;
        while (!done && n < DONE_WAIT) begin
            start = (n < 2 * extra_starts) && (n % 2 == 0);
            @(negedge clk);
            n++;
        end
        start = 1'b0;
        assert (done) else abort_run("done never arrived for the job");
        @(negedge clk);
        assert (job_valid == BLOCKS && job_done == 1)
            else abort_run($sformatf("job gave %0d result blocks and %0d done pulses",
                                     job_valid, job_done));
        assert (!busy) else abort_run("busy still set after done");
        jobs_run++;
    endtask

    // Reset lands after two blocks are out and drops the rest of the job
    task automatic reset_mid_job();
        queue_job();
        blk_idx = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b0;
        @(negedge clk);
        assert (!out_valid && !done && !busy)
            else abort_run("outputs not cleared by reset in the middle of a job");
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        exp_q.delete();
        @(negedge clk);
    endtask

    // Output monitor on the falling edge
    always @(negedge clk) begin
        logic [`MM_WORD_W-1:0] exp_blk;
        assert (!done || out_valid) else abort_run("done pulsed without a result block");
        if (out_valid) begin
            assert (exp_q.size() != 0)
                else abort_run("result block arrived with none expected");
            exp_blk = exp_q.pop_front();
            assert (out_block == exp_blk)
                else abort_run($sformatf("mismatch at %0t: block %0d got %h expected %h",
                                         $time, blk_idx, out_block, exp_blk));
            assert (done == (exp_q.size() == 0))
                else abort_run("done does not line up with the last block of the job");
            blk_idx++;
            job_valid++;
            if (done) begin
                job_done++;
                done_total++;
            end
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) abort_run("timeout, run exceeded its cycle limit");
    end

    initial begin
        int addr;
        logic [7:0] be;
        rst_n = 1'b0;
        start = 1'b0;
        in_en = 1'b0;
        in_we = '0;
        in_addr = '0;
        in_din = '0;
        wb_en = 1'b0;
        wb_we = '0;
        wb_addr = '0;
        wb_din = '0;
        lfsr = SEED;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        load_random(1'b0);          // Full range, all lanes
        load_random(1'b1);
        run_job(0);

        repeat (8) begin            // Lane merges over old words
            addr = int'(rand_bits(8)) % WORDS;
            be = 8'(rand_bits(8));
            if (be == 8'h00) be = 8'h01;
            write_word(rand_bits(1) != 0, addr, be, rand_bits(64));
        end
        run_job(0);

        load_large(1'b0);           // Products big enough to clamp
        load_large(1'b1);
        run_job(0);
        assert (sat_hits > 0) else abort_run("saturation was not reached by the stimulus");

        load_random(1'b0);
        load_random(1'b1);
        run_job(4);                 // Start pulses while busy

        run_job(0);                 // Back to back with new weights
        load_random(1'b1);
        run_job(0);

        reset_mid_job();
        run_job(0);

        if (exp_q.size() != 0 || done_total != jobs_run) begin
            abort_run("expected blocks left over or done count off at the end of the run");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+include
source/mm_pkg.sv
source/tile_if.sv
source/block_ram.sv
source/block_mac.sv
source/mm_controller.sv
source/mm_top.sv
tests/mm_assert.sv
tests/mm_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the block matrix engine testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module mm_tb -f project.f -Mdir obj_dir -o mm_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit $build_status
fi

./obj_dir/mm_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit $sim_status
fi

echo "simulation finished cleanly"
exit 0
